// ==== tb/bus_access_tests.txt ====
# columns: op pipe addr data expected, all numbers but pipe in hex
# fetch: data is the second word, expected the first; fetchload: data is the load address
fetch 0 00000100 cafe0104 cafe0100
fetch 0 00000ff8 cafe0ffc cafe0ff8
load 1 00000200 00000000 cafe0200
load 2 00000204 00000000 cafe0204
store 1 00000300 deadbeef 00000000
load 1 00000300 00000000 deadbeef
load 2 00000300 00000000 deadbeef
store 2 00000304 12345678 00000000
load 2 00000304 00000000 12345678
store 2 00000300 a5a55a5a 00000000
load 1 00000300 00000000 a5a55a5a
fwd 2 00000400 0badf00d 0badf00d
load 1 00000400 00000000 0badf00d
fetchload 1 00000500 00000600 cafe0600
fetchload 2 00000700 00000304 12345678
fetch 0 00000010 cafe0014 cafe0010
store 1 00000010 11112222 00000000
load 2 00000010 00000000 11112222

// ==== bus_access_top.f ====
common/bus_pkg.sv
common/req_if.sv
design/request_capture.sv
read/read_issue.sv
read/read_return.sv
write/write_issue.sv
design/bus_access_top.sv
tb/mem_responder.sv
tb/tb_bus_access_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_bus_access_top \
	-f bus_access_top.f \
	-o sim_bus_access

# tee keeps the pipeline status at zero, the log decides the result
./obj_dir/sim_bus_access 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
if ! grep -q "Verification passed" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation finished cleanly"

// ==== tb/tb_bus_access_top.sv ====
`timescale 1ns/1ps

module tb_bus_access_top;

	localparam logic [31:0] PATTERN_KEY = 32'hcafe0000;
	localparam int CYCLES_PER_TEST = 200;

	logic clk;
	logic rst_n;
	logic fetch_req;
	bus_pkg::addr_t fetch_addr;
	bus_pkg::word_t fetch_inst_1;
	bus_pkg::word_t fetch_inst_2;
	logic fetch_valid;
	logic load_req_1;
	bus_pkg::addr_t load_addr_1;
	bus_pkg::word_t load_data_1;
	logic load_valid_1;
	logic load_req_2;
	bus_pkg::addr_t load_addr_2;
	bus_pkg::word_t load_data_2;
	logic load_valid_2;
	logic store_req_1;
	bus_pkg::addr_t store_addr_1;
	bus_pkg::word_t store_data_1;
	logic store_valid_1;
	logic store_req_2;
	bus_pkg::addr_t store_addr_2;
	bus_pkg::word_t store_data_2;
	logic store_valid_2;
	logic stall;
	logic fetch_wait;
	logic arvalid;
	logic arready;
	bus_pkg::axi_id_t arid;
	bus_pkg::addr_t araddr;
	bus_pkg::burst_len_t arlen;
	logic rvalid;
	bus_pkg::axi_id_t rid;
	bus_pkg::word_t rdata;
	logic rlast;
	logic awvalid;
	logic awready;
	bus_pkg::addr_t awaddr;
	logic wvalid;
	logic wready;
	bus_pkg::word_t wdata;
	logic wlast;
	logic bvalid;
	logic bready;

	// test table from the data file
	string op_q[$];
	int pipe_q[$];
	bus_pkg::addr_t addr_q[$];
	bus_pkg::word_t data_q[$];
	bus_pkg::word_t exp_q[$];
	int n_tests;
	bit tests_loaded;
	int error_count;

	// read address handshakes seen so far
	int ar_count;
	bus_pkg::axi_id_t ar_ids[$];
	bus_pkg::burst_len_t ar_lens[$];

	bus_access_top bus_access_top_i (.*);

	mem_responder #(.PATTERN_KEY(PATTERN_KEY)) mem_responder_i (.*);

	always #2 clk = ~clk;

	// counted mid-cycle where the address channel is stable
	always @(negedge clk)
	begin
		if (rst_n && arvalid && arready)
		begin
			ar_count = ar_count + 1;
			ar_ids.push_back(arid);
			ar_lens.push_back(arlen);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task fail_now(input string what);
		error_count++;
		$display("%s", what);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input bus_pkg::word_t exp,
		input bus_pkg::word_t act);
		assert (act === exp)
		else
			fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		assert (act === exp)
		else
			fail_now($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		assert (act == exp)
		else
			fail_now($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// every write is a single beat so wlast rides with wvalid
	always @(negedge clk)
	begin
		if (rst_n && wvalid)
			check_bit("write beat wlast", 1'b1, wlast);
	end

	function automatic bus_pkg::word_t pattern_word(input bus_pkg::addr_t a);
		return a ^ PATTERN_KEY;
	endfunction

	function automatic logic load_valid_of(input int pipe);
		return (pipe == 1) ? load_valid_1 : load_valid_2;
	endfunction

	function automatic bus_pkg::word_t load_data_of(input int pipe);
		return (pipe == 1) ? load_data_1 : load_data_2;
	endfunction

	function automatic logic store_valid_of(input int pipe);
		return (pipe == 1) ? store_valid_1 : store_valid_2;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// request drivers for use right after a rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic start_load(input int pipe, input bus_pkg::addr_t a);
		if (pipe == 1)
		begin
			load_req_1 <= 1'b1;
			load_addr_1 <= a;
		end
		else
		begin
			load_req_2 <= 1'b1;
			load_addr_2 <= a;
		end
	endtask

	task automatic start_store(input int pipe, input bus_pkg::addr_t a,
		input bus_pkg::word_t d);
		if (pipe == 1)
		begin
			store_req_1 <= 1'b1;
			store_addr_1 <= a;
			store_data_1 <= d;
		end
		else
		begin
			store_req_2 <= 1'b1;
			store_addr_2 <= a;
			store_data_2 <= d;
		end
	endtask

	task end_requests;
		fetch_req <= 1'b0;
		load_req_1 <= 1'b0;
		load_req_2 <= 1'b0;
		store_req_1 <= 1'b0;
		store_req_2 <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// one task per kind of test
	////////////////////////////////////////////////////////////////////////////

	task automatic run_fetch(input string name, input bus_pkg::addr_t a,
		input bus_pkg::word_t exp_1, input bus_pkg::word_t exp_2);
		int ar_before;
		@(posedge clk);
		ar_before = ar_count;
		fetch_req <= 1'b1;
		fetch_addr <= a;
		@(posedge clk);
		end_requests();
		do
		begin
			@(negedge clk);
			check_bit({name, " fetch_wait"}, 1'b1, fetch_wait);
		end
		while (!fetch_valid);
		check_word({name, " inst 1"}, exp_1, fetch_inst_1);
		check_word({name, " inst 2"}, exp_2, fetch_inst_2);
		@(posedge clk);
		check_count({name, " read handshakes"}, ar_before + 1, ar_count);
		// two-beat burst
		check_count({name, " arlen"}, 1, int'(ar_lens[ar_before]));
	endtask

	task automatic run_load(input string name, input int pipe, input bus_pkg::addr_t a,
		input bus_pkg::word_t exp);
		int ar_before;
		@(posedge clk);
		ar_before = ar_count;
		start_load(pipe, a);
		@(posedge clk);
		end_requests();
		do
		begin
			@(negedge clk);
			check_bit({name, " stall"}, 1'b1, stall);
		end
		while (!load_valid_of(pipe));
		check_word({name, " load data"}, exp, load_data_of(pipe));
		@(posedge clk);
		check_count({name, " read handshakes"}, ar_before + 1, ar_count);
		check_count({name, " arid"}, pipe, int'(ar_ids[ar_before]));
	endtask

	task automatic run_store(input string name, input int pipe, input bus_pkg::addr_t a,
		input bus_pkg::word_t d);
		@(posedge clk);
		start_store(pipe, a, d);
		@(posedge clk);
		end_requests();
		do
		begin
			@(negedge clk);
			check_bit({name, " stall"}, 1'b1, stall);
		end
		while (!store_valid_of(pipe));
	endtask

	// pipe-1 store and pipe-2 load to one address in the same cycle
	task automatic run_forward(input string name, input bus_pkg::addr_t a,
		input bus_pkg::word_t d, input bus_pkg::word_t exp);
		int ar_before;
		logic got_load;
		logic got_store;
		bus_pkg::word_t ld;
		@(posedge clk);
		ar_before = ar_count;
		start_store(1, a, d);
		start_load(2, a);
		@(posedge clk);
		end_requests();
		got_load = 1'b0;
		got_store = 1'b0;
		while (!(got_load && got_store))
		begin
			@(negedge clk);
			if (load_valid_2)
			begin
				got_load = 1'b1;
				ld = load_data_2;
			end
			if (store_valid_1)
				got_store = 1'b1;
		end
		check_word({name, " forwarded data"}, exp, ld);
		@(posedge clk);
		check_count({name, " read handshakes"}, ar_before, ar_count);
	endtask

	task automatic run_fetch_load(input string name, input int pipe,
		input bus_pkg::addr_t fa, input bus_pkg::addr_t la, input bus_pkg::word_t exp);
		int ar_before;
		logic got_fetch;
		logic got_load;
		bus_pkg::word_t inst_1;
		bus_pkg::word_t inst_2;
		bus_pkg::word_t ld;
		@(posedge clk);
		ar_before = ar_count;
		fetch_req <= 1'b1;
		fetch_addr <= fa;
		start_load(pipe, la);
		@(posedge clk);
		end_requests();
		got_fetch = 1'b0;
		got_load = 1'b0;
		while (!(got_fetch && got_load))
		begin
			@(negedge clk);
			if (fetch_valid)
			begin
				got_fetch = 1'b1;
				inst_1 = fetch_inst_1;
				inst_2 = fetch_inst_2;
			end
			if (load_valid_of(pipe))
			begin
				got_load = 1'b1;
				ld = load_data_of(pipe);
			end
		end
		check_word({name, " inst 1"}, pattern_word(fa), inst_1);
		check_word({name, " inst 2"}, pattern_word(fa + 32'd4), inst_2);
		check_word({name, " load data"}, exp, ld);
		@(posedge clk);
		check_count({name, " read handshakes"}, ar_before + 2, ar_count);
		// fetch wins the first address slot
		check_count({name, " first arid"}, 0, int'(ar_ids[ar_before]));
		check_count({name, " second arid"}, pipe, int'(ar_ids[ar_before + 1]));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int fd;
		int n;
		int pipe;
		string line;
		string op;
		string name;
		bus_pkg::addr_t a;
		bus_pkg::word_t d;
		bus_pkg::word_t e;

		clk = 1'b0;
		rst_n = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		load_req_1 = 1'b0;
		load_addr_1 = '0;
		load_req_2 = 1'b0;
		load_addr_2 = '0;
		store_req_1 = 1'b0;
		store_addr_1 = '0;
		store_data_1 = '0;
		store_req_2 = 1'b0;
		store_addr_2 = '0;
		store_data_2 = '0;
		error_count = 0;
		ar_count = 0;
		tests_loaded = 1'b0;

		fd = $fopen("tb/bus_access_tests.txt", "r");
		if (fd == 0)
			fail_now("could not open the test file tb/bus_access_tests.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %d %h %h %h", op, pipe, a, d, e);
			if (n != 5)
				fail_now({"malformed line in the test file: ", line});
			op_q.push_back(op);
			pipe_q.push_back(pipe);
			addr_q.push_back(a);
			data_q.push_back(d);
			exp_q.push_back(e);
		end
		$fclose(fd);
		n_tests = op_q.size();
		tests_loaded = 1'b1;

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit("reset stall", 1'b0, stall);
		check_bit("reset fetch_wait", 1'b0, fetch_wait);
		check_bit("reset arvalid", 1'b0, arvalid);
		check_bit("reset awvalid", 1'b0, awvalid);
		check_bit("reset wvalid", 1'b0, wvalid);
		check_bit("reset bready", 1'b0, bready);

		for (int t = 0; t < n_tests; t++)
		begin
			name = $sformatf("%0d_%s", t, op_q[t]);
			if (op_q[t] == "fetch")
				run_fetch(name, addr_q[t], exp_q[t], data_q[t]);
			else if (op_q[t] == "load")
				run_load(name, pipe_q[t], addr_q[t], exp_q[t]);
			else if (op_q[t] == "store")
				run_store(name, pipe_q[t], addr_q[t], data_q[t]);
			else if (op_q[t] == "fwd")
				run_forward(name, addr_q[t], data_q[t], exp_q[t]);
			else if (op_q[t] == "fetchload")
				run_fetch_load(name, pipe_q[t], addr_q[t], data_q[t], exp_q[t]);
			else
				fail_now({"unknown operation in the test file: ", op_q[t]});
		end

		if (error_count == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
		begin
			$display("Verification failed");
			$fatal(1);
		end
	end

	// budget grows with the number of tests
	initial
	begin
		wait (tests_loaded);
		repeat (n_tests * CYCLES_PER_TEST + 20) @(posedge clk);
		fail_now("timeout: the tests did not finish in the allowed number of cycles");
	end

endmodule

// ==== tb/mem_responder.sv ====
`timescale 1ns/1ps

module mem_responder
#(
	parameter logic [31:0] PATTERN_KEY = 32'hcafe0000
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic arvalid,
	output logic arready,
	input  bus_pkg::axi_id_t arid,
	input  bus_pkg::addr_t araddr,
	input  bus_pkg::burst_len_t arlen,
	output logic rvalid,
	output bus_pkg::axi_id_t rid,
	output bus_pkg::word_t rdata,
	output logic rlast,
	input  logic awvalid,
	output logic awready,
	input  bus_pkg::addr_t awaddr,
	input  logic wvalid,
	output logic wready,
	input  bus_pkg::word_t wdata,
	output logic bvalid,
	input  logic bready
);

	bus_pkg::word_t mem [0:1023];
	logic [31:0] lcg_state;
	logic rd_active;
	bus_pkg::axi_id_t rd_id;
	bus_pkg::addr_t rd_addr;
	bus_pkg::burst_len_t rd_left;
	logic aw_got;
	logic w_got;
	bus_pkg::addr_t aw_addr;
	bus_pkg::word_t w_data;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// each word holds its own byte address xor the key
	initial
	begin
		lcg_state = 32'h107ee90a;
		arready = 1'b0;
		rvalid = 1'b0;
		rid = '0;
		rdata = '0;
		rlast = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		rd_active = 1'b0;
		aw_got = 1'b0;
		w_got = 1'b0;
		for (int i = 0; i < 1024; i++)
			mem[i] = (i << 2) ^ PATTERN_KEY;
	end

	always @(posedge clk)
	begin
		lcg_state <= lcg_next(lcg_state);
		if (!rst_n)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			rd_active <= 1'b0;
			aw_got <= 1'b0;
			w_got <= 1'b0;
		end
		else
		begin
			// each ready high about half the time from upper lcg bits
			arready <= lcg_state[16];
			awready <= lcg_state[19];
			wready <= lcg_state[23];

			////////////////////////////////////////////////////////////////////////////
			// read channel
			////////////////////////////////////////////////////////////////////////////

			if (arvalid && arready)
			begin
				rd_active <= 1'b1;
				rd_id <= arid;
				rd_addr <= araddr;
				rd_left <= arlen;
			end
			rvalid <= 1'b0;
			rlast <= 1'b0;
			// random gaps between beats
			if (rd_active && lcg_state[27])
			begin
				rvalid <= 1'b1;
				rid <= rd_id;
				rdata <= mem[rd_addr[11:2]];
				rlast <= (rd_left == 4'd0);
				rd_addr <= rd_addr + 32'd4;
				if (rd_left == 4'd0)
					rd_active <= 1'b0;
				else
					rd_left <= rd_left - 4'd1;
			end

			////////////////////////////////////////////////////////////////////////////
			// write channel
			////////////////////////////////////////////////////////////////////////////

			if (awvalid && awready)
			begin
				aw_got <= 1'b1;
				aw_addr <= awaddr;
			end
			if (wvalid && wready)
			begin
				w_got <= 1'b1;
				w_data <= wdata;
			end
			if (aw_got && w_got && !bvalid)
			begin
				mem[aw_addr[11:2]] <= w_data;
				aw_got <= 1'b0;
				w_got <= 1'b0;
				bvalid <= 1'b1;
			end
			if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

endmodule

// ==== design/bus_access_top.sv ====
`timescale 1ns/1ps

module bus_access_top
(
	input  logic clk,
	input  logic rst_n,

	// fetch side
	input  logic fetch_req,
	input  bus_pkg::addr_t fetch_addr,
	output bus_pkg::word_t fetch_inst_1,
	output bus_pkg::word_t fetch_inst_2,
	output logic fetch_valid,

	// loads
	input  logic load_req_1,
	input  bus_pkg::addr_t load_addr_1,
	output bus_pkg::word_t load_data_1,
	output logic load_valid_1,
	input  logic load_req_2,
	input  bus_pkg::addr_t load_addr_2,
	output bus_pkg::word_t load_data_2,
	output logic load_valid_2,

	// stores
	input  logic store_req_1,
	input  bus_pkg::addr_t store_addr_1,
	input  bus_pkg::word_t store_data_1,
	output logic store_valid_1,
	input  logic store_req_2,
	input  bus_pkg::addr_t store_addr_2,
	input  bus_pkg::word_t store_data_2,
	output logic store_valid_2,

	output logic stall,
	output logic fetch_wait,

	// read address and return
	output logic arvalid,
	input  logic arready,
	output bus_pkg::axi_id_t arid,
	output bus_pkg::addr_t araddr,
	output bus_pkg::burst_len_t arlen,
	input  logic rvalid,
	input  bus_pkg::axi_id_t rid,
	input  bus_pkg::word_t rdata,
	input  logic rlast,

	// write address, data and response
	output logic awvalid,
	input  logic awready,
	output bus_pkg::addr_t awaddr,
	output logic wvalid,
	input  logic wready,
	output bus_pkg::word_t wdata,
	output logic wlast,
	input  logic bvalid,
	output logic bready
);

	req_if req_i();

	request_capture request_capture_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.load_req_1(load_req_1),
		.load_addr_1(load_addr_1),
		.load_req_2(load_req_2),
		.load_addr_2(load_addr_2),
		.store_req_1(store_req_1),
		.store_addr_1(store_addr_1),
		.store_data_1(store_data_1),
		.store_req_2(store_req_2),
		.store_addr_2(store_addr_2),
		.store_data_2(store_data_2),
		.stall(stall),
		.fetch_wait(fetch_wait),
		.req(req_i.capture)
	);

	read_issue read_issue_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.req(req_i.read_issue),
		.arvalid(arvalid),
		.arready(arready),
		.arid(arid),
		.araddr(araddr),
		.arlen(arlen)
	);

	read_return read_return_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.req(req_i.read_return),
		.rvalid(rvalid),
		.rid(rid),
		.rdata(rdata),
		.rlast(rlast),
		.fetch_inst_1(fetch_inst_1),
		.fetch_inst_2(fetch_inst_2),
		.fetch_valid(fetch_valid),
		.load_data_1(load_data_1),
		.load_data_2(load_data_2),
		.load_valid_1(load_valid_1),
		.load_valid_2(load_valid_2)
	);

	write_issue write_issue_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.req(req_i.write_issue),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wlast(wlast),
		.bvalid(bvalid),
		.bready(bready),
		.store_valid_1(store_valid_1),
		.store_valid_2(store_valid_2)
	);

endmodule

// ==== write/write_issue.sv ====
`timescale 1ns/1ps

module write_issue
(
	input  logic clk,
	input  logic rst_n,
	req_if.write_issue req,
	output logic awvalid,
	input  logic awready,
	output bus_pkg::addr_t awaddr,
	output logic wvalid,
	input  logic wready,
	output bus_pkg::word_t wdata,
	output logic wlast,
	input  logic bvalid,
	output logic bready,
	output logic store_valid_1,
	output logic store_valid_2
);

	bus_pkg::wr_state_t state;
	logic sel_2;
	logic go_1;
	logic go_2;
	logic aw_left;
	logic w_left;

	// a store in its done cycle is still flagged
	assign go_1 = req.store_pending_1 & ~req.store_done_1;
	assign go_2 = req.store_pending_2 & ~req.store_done_2;

	// channels still waiting after this edge
	assign aw_left = awvalid & ~awready;
	assign w_left = wvalid & ~wready;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= bus_pkg::WR_IDLE;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			wlast <= 1'b0;
			bready <= 1'b0;
			store_valid_1 <= 1'b0;
			store_valid_2 <= 1'b0;
		end
		else
		begin
			store_valid_1 <= 1'b0;
			store_valid_2 <= 1'b0;
			case (state)
				bus_pkg::WR_IDLE:
				begin
					if (go_1 || go_2)
					begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						wlast <= 1'b1;
						state <= bus_pkg::WR_ADDR_DATA;
					end
				end
				bus_pkg::WR_ADDR_DATA:
				begin
					// address and data accepted in any order
					awvalid <= aw_left;
					wvalid <= w_left;
					wlast <= w_left;
					if (!aw_left && !w_left)
					begin
						bready <= 1'b1;
						state <= bus_pkg::WR_RESP;
					end
				end
				bus_pkg::WR_RESP:
				begin
					if (bvalid)
					begin
						bready <= 1'b0;
						store_valid_1 <= ~sel_2;
						store_valid_2 <= sel_2;
						state <= bus_pkg::WR_IDLE;
					end
				end
				default:
					state <= bus_pkg::WR_IDLE;
			endcase
		end
	end

	// store 1 before store 2
	always_ff @(posedge clk)
	begin
		if (state == bus_pkg::WR_IDLE && (go_1 || go_2))
		begin
			sel_2 <= ~go_1;
			awaddr <= go_1 ? req.store_addr_1 : req.store_addr_2;
			wdata <= go_1 ? req.store_data_1 : req.store_data_2;
		end
	end

	assign req.store_done_1 = store_valid_1;
	assign req.store_done_2 = store_valid_2;

endmodule

// ==== read/read_return.sv ====
`timescale 1ns/1ps

module read_return
(
	input  logic clk,
	input  logic rst_n,
	req_if.read_return req,
	input  logic rvalid,
	input  bus_pkg::axi_id_t rid,
	input  bus_pkg::word_t rdata,
	input  logic rlast,
	output bus_pkg::word_t fetch_inst_1,
	output bus_pkg::word_t fetch_inst_2,
	output logic fetch_valid,
	output bus_pkg::word_t load_data_1,
	output bus_pkg::word_t load_data_2,
	output logic load_valid_1,
	output logic load_valid_2
);

	logic fetch_beat;
	logic load_valid_2_q;
	bus_pkg::word_t load_data_2_q;
	logic is_fetch;
	logic is_load_1;
	logic is_load_2;

	assign is_fetch = rvalid && (rid == bus_pkg::ID_FETCH);
	assign is_load_1 = rvalid && (rid == bus_pkg::ID_LOAD_1);
	assign is_load_2 = rvalid && (rid == bus_pkg::ID_LOAD_2);

	// beat counter restarts after the last fetch beat
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fetch_beat <= 1'b0;
			fetch_valid <= 1'b0;
			load_valid_1 <= 1'b0;
			load_valid_2_q <= 1'b0;
		end
		else
		begin
			if (is_fetch)
				fetch_beat <= ~rlast;
			fetch_valid <= is_fetch & rlast;
			load_valid_1 <= is_load_1 & rlast;
			load_valid_2_q <= is_load_2 & rlast;
		end
	end

	// beat 0 to pipe 1, beat 1 to pipe 2
	always_ff @(posedge clk)
	begin
		if (is_fetch && !fetch_beat)
			fetch_inst_1 <= rdata;
		if (is_fetch && fetch_beat)
			fetch_inst_2 <= rdata;
		if (is_load_1)
			load_data_1 <= rdata;
		if (req.fwd_done_2)
			load_data_2_q <= req.fwd_data_2;
		else if (is_load_2)
			load_data_2_q <= rdata;
	end

	// forwarded result bypasses the register for one cycle
	assign load_valid_2 = load_valid_2_q | req.fwd_done_2;
	assign load_data_2 = req.fwd_done_2 ? req.fwd_data_2 : load_data_2_q;

	assign req.fetch_done = fetch_valid;
	assign req.load_done_1 = load_valid_1;
	assign req.load_done_2 = load_valid_2_q;
	assign req.read_last = rvalid & rlast;

endmodule

// ==== read/read_issue.sv ====
`timescale 1ns/1ps

module read_issue
(
	input  logic clk,
	input  logic rst_n,
	req_if.read_issue req,
	output logic arvalid,
	input  logic arready,
	output bus_pkg::axi_id_t arid,
	output bus_pkg::addr_t araddr,
	output bus_pkg::burst_len_t arlen
);

	logic fetch_go;
	logic load1_go;
	logic load2_live;
	logic load2_go;
	logic fwd_hit;
	logic pick_any;
	bus_pkg::axi_id_t pick_id;
	bus_pkg::addr_t pick_addr;
	bus_pkg::burst_len_t pick_len;

	// a request in its done cycle is still flagged, so mask it
	assign fetch_go = req.fetch_pending & ~req.fetch_done;
	assign load1_go = req.load_pending_1 & ~req.load_done_1;
	assign load2_live = req.load_pending_2 & ~req.load_done_2 & ~req.fwd_done_2;

	// pipe-2 load hits the pending pipe-1 store, unless already on the bus
	assign fwd_hit = load2_live & req.store_pending_1
		& (req.load_addr_2 == req.store_addr_1)
		& ~(req.read_busy & (arid == bus_pkg::ID_LOAD_2));
	assign load2_go = load2_live & ~fwd_hit;

	assign pick_any = fetch_go | load1_go | load2_go;

	// fixed priority: fetch, load 1, load 2
	always_comb
	begin
		pick_id = bus_pkg::ID_LOAD_2;
		pick_addr = req.load_addr_2;
		pick_len = bus_pkg::LOAD_LEN;
		if (fetch_go)
		begin
			pick_id = bus_pkg::ID_FETCH;
			pick_addr = req.fetch_addr;
			pick_len = bus_pkg::FETCH_LEN;
		end
		else if (load1_go)
		begin
			pick_id = bus_pkg::ID_LOAD_1;
			pick_addr = req.load_addr_1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// address channel and busy flag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			arvalid <= 1'b0;
			req.read_busy <= 1'b0;
			req.fwd_done_2 <= 1'b0;
		end
		else
		begin
			req.fwd_done_2 <= fwd_hit;
			if (req.read_busy)
			begin
				if (arvalid && arready)
					arvalid <= 1'b0;
				if (req.read_last)
					req.read_busy <= 1'b0;
			end
			else if (pick_any)
			begin
				arvalid <= 1'b1;
				req.read_busy <= 1'b1;
			end
		end
	end

	// payload held until the handshake, arid kept for the forward guard
	always_ff @(posedge clk)
	begin
		if (!req.read_busy && pick_any)
		begin
			arid <= pick_id;
			araddr <= pick_addr;
			arlen <= pick_len;
		end
		if (fwd_hit)
			req.fwd_data_2 <= req.store_data_1;
	end

endmodule

// ==== design/request_capture.sv ====
`timescale 1ns/1ps

module request_capture
(
	input  logic clk,
	input  logic rst_n,
	input  logic fetch_req,
	input  bus_pkg::addr_t fetch_addr,
	input  logic load_req_1,
	input  bus_pkg::addr_t load_addr_1,
	input  logic load_req_2,
	input  bus_pkg::addr_t load_addr_2,
	input  logic store_req_1,
	input  bus_pkg::addr_t store_addr_1,
	input  bus_pkg::word_t store_data_1,
	input  logic store_req_2,
	input  bus_pkg::addr_t store_addr_2,
	input  bus_pkg::word_t store_data_2,
	output logic stall,
	output logic fetch_wait,
	req_if.capture req
);

	// bit order: fetch, load 1, load 2, store 1, store 2
	logic [4:0] req_vec;
	logic [4:0] done_vec;
	logic [4:0] pend_q;

	assign req_vec = {store_req_2, store_req_1, load_req_2, load_req_1, fetch_req};

	// forwarded load 2 also completes the load
	assign done_vec = {req.store_done_2, req.store_done_1,
		req.load_done_2 | req.fwd_done_2, req.load_done_1, req.fetch_done};

	// a new pulse wins over a clear in the same cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pend_q <= '0;
		else
			pend_q <= (pend_q & ~done_vec) | req_vec;
	end

	// addresses and store data ride along with the pulse
	always_ff @(posedge clk)
	begin
		if (fetch_req)
			req.fetch_addr <= fetch_addr;
		if (load_req_1)
			req.load_addr_1 <= load_addr_1;
		if (load_req_2)
			req.load_addr_2 <= load_addr_2;
		if (store_req_1)
		begin
			req.store_addr_1 <= store_addr_1;
			req.store_data_1 <= store_data_1;
		end
		if (store_req_2)
		begin
			req.store_addr_2 <= store_addr_2;
			req.store_data_2 <= store_data_2;
		end
	end

	assign req.fetch_pending = pend_q[0];
	assign req.load_pending_1 = pend_q[1];
	assign req.load_pending_2 = pend_q[2];
	assign req.store_pending_1 = pend_q[3];
	assign req.store_pending_2 = pend_q[4];

	// data side holds the memory stage, fetch side holds the pc
	assign stall = |pend_q[4:1];
	assign fetch_wait = pend_q[0];

endmodule

// ==== common/req_if.sv ====
`timescale 1ns/1ps

interface req_if;

	// pending requests, from capture
	logic fetch_pending;
	bus_pkg::addr_t fetch_addr;
	logic load_pending_1;
	logic load_pending_2;
	bus_pkg::addr_t load_addr_1;
	bus_pkg::addr_t load_addr_2;
	logic store_pending_1;
	logic store_pending_2;
	bus_pkg::addr_t store_addr_1;
	bus_pkg::addr_t store_addr_2;
	bus_pkg::word_t store_data_1;
	bus_pkg::word_t store_data_2;

	// read side status
	logic read_busy;
	logic fwd_done_2;
	bus_pkg::word_t fwd_data_2;
	logic fetch_done;
	logic load_done_1;
	logic load_done_2;
	logic read_last;

	// write side status
	logic store_done_1;
	logic store_done_2;

	modport capture
	(
		output fetch_pending, fetch_addr,
		output load_pending_1, load_pending_2, load_addr_1, load_addr_2,
		output store_pending_1, store_pending_2, store_addr_1, store_addr_2,
		output store_data_1, store_data_2,
		input fetch_done, load_done_1, load_done_2, fwd_done_2,
		input store_done_1, store_done_2
	);

	modport read_issue
	(
		input fetch_pending, fetch_addr,
		input load_pending_1, load_pending_2, load_addr_1, load_addr_2,
		input store_pending_1, store_addr_1, store_data_1,
		input fetch_done, load_done_1, load_done_2, read_last,
		output read_busy, fwd_done_2, fwd_data_2
	);

	modport read_return
	(
		input fwd_done_2, fwd_data_2,
		output fetch_done, load_done_1, load_done_2, read_last
	);

	modport write_issue
	(
		input store_pending_1, store_pending_2, store_addr_1, store_addr_2,
		input store_data_1, store_data_2,
		output store_done_1, store_done_2
	);

endinterface

// ==== common/bus_pkg.sv ====
package bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	// byte address
	typedef logic [31:0] addr_t;

	// instruction or data word
	typedef logic [31:0] word_t;

	// read transaction id
	typedef logic [3:0] axi_id_t;

	// beats minus one
	typedef logic [3:0] burst_len_t;

	////////////////////////////////////////////////////////////////////////////
	// read ids and burst lengths
	////////////////////////////////////////////////////////////////////////////

	localparam axi_id_t ID_FETCH  = 4'd0;
	localparam axi_id_t ID_LOAD_1 = 4'd1;
	localparam axi_id_t ID_LOAD_2 = 4'd2;

	// fetch pair is a two-beat burst
	localparam burst_len_t FETCH_LEN = 4'd1;
	localparam burst_len_t LOAD_LEN  = 4'd0;

	// write channel FSM
	typedef enum logic [1:0]
	{
		WR_IDLE,
		WR_ADDR_DATA,
		WR_RESP
	} wr_state_t;

endpackage
